// File: pattern_gen_top.f
+incdir+.
pattern_gen_pkg.sv
raster_timing.sv
square_motion.sv
pixel_compose.sv
pattern_gen_top.sv
tb_pattern_gen.sv

// File: Makefile
# Verilator build and run for the test-pattern core

TOP := tb_pattern_gen

all: run

build:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f pattern_gen_top.f

run: build
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q '>>> FAIL' sim.log; then exit 1; fi
	@grep -q '>>> PASS' sim.log

lint:
	verilator --lint-only --timing -Wall --top-module pattern_gen_top -f pattern_gen_top.f

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

// File: tb_pattern_gen.sv
/*
 * directed testbench for the test-pattern core
 * clock and reset, frame-stepped square model, compare tasks, tests
 */

`timescale 1ns/1ps
`default_nettype none

`include "pattern_gen_cfg.svh"

module tb_pattern_gen;

    // reduced raster, many frames in little time
    localparam int H_BPORCH = 8;
    localparam int H_ACTIVE = 32;
    localparam int H_TOTAL  = 48;
    localparam int V_BPORCH = 4;
    localparam int V_ACTIVE = 24;
    localparam int V_TOTAL  = 30;
    localparam int SIZE     = 5;
    localparam int X0       = 2;
    localparam int Y0       = 16;
    localparam int W        = `PG_COORD_W;
    localparam int FRAME    = H_TOTAL * V_TOTAL;
    localparam int TIMEOUT  = 3 * FRAME;

    localparam pattern_gen_pkg::video_out_t IDLE = '0;

    logic                        audgen_mclk;
    logic                        reset_n;
    pattern_gen_pkg::video_out_t video;

    // cycles since reset release, counted at the sample point
    int                    cyc;
    // square model, position and direction per axis
    int                    mx;
    int                    my;
    pattern_gen_pkg::dir_t mdx;
    pattern_gen_pkg::dir_t mdy;
    int                    checks;
    int                    errors;
    logic [31:0]           rng;

    pattern_gen_top #(
        .H_BPORCH    (H_BPORCH),
        .H_ACTIVE    (H_ACTIVE),
        .H_TOTAL     (H_TOTAL),
        .V_BPORCH    (V_BPORCH),
        .V_ACTIVE    (V_ACTIVE),
        .V_TOTAL     (V_TOTAL),
        .SQUARE_SIZE (SIZE),
        .SQUARE_X0   (X0),
        .SQUARE_Y0   (Y0)
    ) i_dut (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .video       (video)
    );

    // 40 ns period
    always #20 audgen_mclk = ~audgen_mclk;

    ////////////////////
    // model
    ////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] v;
        v = s;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    // reverse at the limit ahead, then one pixel on
    task automatic step_model();
        if (mdx == pattern_gen_pkg::DIR_DEC && mx == 0) begin
            mdx = pattern_gen_pkg::DIR_INC;
        end else if (mdx == pattern_gen_pkg::DIR_INC && mx == H_ACTIVE - SIZE) begin
            mdx = pattern_gen_pkg::DIR_DEC;
        end
        if (mdy == pattern_gen_pkg::DIR_DEC && my == 0) begin
            mdy = pattern_gen_pkg::DIR_INC;
        end else if (mdy == pattern_gen_pkg::DIR_INC && my == V_ACTIVE - SIZE) begin
            mdy = pattern_gen_pkg::DIR_DEC;
        end
        mx = (mdx == pattern_gen_pkg::DIR_INC) ? mx + 1 : mx - 1;
        my = (mdy == pattern_gen_pkg::DIR_INC) ? my + 1 : my - 1;
    endtask

    function automatic pattern_gen_pkg::square_pos_t model_square();
        pattern_gen_pkg::square_pos_t s;
        s.x = W'(mx);
        s.y = W'(my);
        return s;
    endfunction

    // expected output n cycles after vs, raster position n
    function automatic pattern_gen_pkg::video_out_t expect_pixel(input int n);
        pattern_gen_pkg::video_out_t v;
        int vx;
        int vy;
        vx = n % H_TOTAL - H_BPORCH;
        vy = n / H_TOTAL - V_BPORCH;
        v = '0;
        v.vs = (n == 0);
        v.hs = (n % H_TOTAL == `PG_HS_OFFSET);
        v.de = (vx >= 0) && (vx < H_ACTIVE) && (vy >= 0) && (vy < V_ACTIVE);
        // gray unless inside the black square
        if (v.de && !(vx >= mx && vx < mx + SIZE && vy >= my && vy < my + SIZE)) begin
            v.rgb.r = 8'(`PG_BG_LEVEL);
            v.rgb.g = 8'(`PG_BG_LEVEL);
            v.rgb.b = 8'(`PG_BG_LEVEL);
        end
        return v;
    endfunction

    ////////////////////
    // compare tasks
    ////////////////////

    task automatic check_video(input pattern_gen_pkg::video_out_t got,
                               input pattern_gen_pkg::video_out_t exp,
                               input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t ns video (%s): got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_square(input pattern_gen_pkg::square_pos_t got,
                                input pattern_gen_pkg::square_pos_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t ns square: got x=%0d y=%0d expected x=%0d y=%0d",
                     $time, got.x, got.y, exp.x, exp.y);
        end
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("[ERROR] %0t ns %s: got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    ////////////////////
    // cycle helpers
    ////////////////////

    task automatic abort_run(input string what);
        $display("timeout at %0t ns: %s", $time, what);
        $display("checks %0d, errors %0d", checks, errors + 1);
        $display(">>> FAIL");
        $finish;
    endtask

    // sample mid-cycle, model steps with each expected vs
    task automatic next_cycle();
        @(negedge audgen_mclk);
        cyc++;
        if (cyc % FRAME == 1) begin
            step_model();
        end
    endtask

    // video must stay idle during reset and one cycle after
    task automatic apply_reset();
        @(posedge audgen_mclk);
        reset_n <= 1'b0;
        repeat (16) begin
            @(negedge audgen_mclk);
            check_video(video, IDLE, "in reset");
            @(posedge audgen_mclk);
        end
        reset_n <= 1'b1;
        mx  = X0;
        my  = Y0;
        mdx = pattern_gen_pkg::DIR_DEC;
        mdy = pattern_gen_pkg::DIR_INC;
        cyc = 0;
        @(negedge audgen_mclk);
        check_video(video, IDLE, "first cycle after reset");
    endtask

    // stops on the sample that carries vs
    task automatic wait_vs();
        int n;
        n = 0;
        next_cycle();
        while (!video.vs && n < TIMEOUT) begin
            next_cycle();
            n++;
        end
        if (!video.vs) begin
            abort_run("no vs within three frames");
        end
    endtask

    // top-left black pixel of one frame, starting on its vs sample
    task automatic measure_square(output pattern_gen_pkg::square_pos_t pos);
        bit found;
        found = 1'b0;
        pos   = '1;
        for (int n = 0; n < FRAME; n++) begin
            if (!found && video.de && video.rgb == '0) begin
                found = 1'b1;
                pos.x = W'(n % H_TOTAL - H_BPORCH);
                pos.y = W'(n / H_TOTAL - V_BPORCH);
            end
            next_cycle();
        end
        if (!found) begin
            $display("error at %0t ns: no black square found in the frame", $time);
        end
    endtask

    task automatic track_frames(input int frames);
        pattern_gen_pkg::square_pos_t got;
        pattern_gen_pkg::square_pos_t exp;
        repeat (frames) begin
            exp = model_square();
            measure_square(got);
            check_square(got, exp);
        end
    endtask

    ////////////////////
    // tests
    ////////////////////

    task automatic test_reset_state();
        apply_reset();
    endtask

    task automatic test_sync_timing();
        int vs_count;
        int vs_at;
        int hs_count;
        int last_hs;
        vs_count = 0;
        vs_at    = 0;
        hs_count = 0;
        last_hs  = 0;
        wait_vs();
        check_count("vs cycle after reset", cyc % FRAME, 1);
        // one frame on, ending on the next vs
        for (int n = 1; n <= FRAME; n++) begin
            next_cycle();
            if (video.vs) begin
                vs_count++;
                vs_at = n;
            end
            if (video.hs) begin
                if (hs_count == 0) begin
                    check_count("vs to first hs", n, `PG_HS_OFFSET);
                end else begin
                    check_count("hs period", n - last_hs, H_TOTAL);
                end
                hs_count++;
                last_hs = n;
            end
        end
        check_count("vs pulses per frame", vs_count, 1);
        check_count("vs period", vs_at, FRAME);
        check_count("hs pulses per frame", hs_count, V_TOTAL);
    endtask

    task automatic test_active_window();
        int  since_hs;
        int  line_de;
        int  lines;
        bit  prev_de;
        since_hs = 0;
        line_de  = 0;
        lines    = 0;
        prev_de  = 1'b0;
        wait_vs();
        repeat (FRAME) begin
            next_cycle();
            since_hs = video.hs ? 0 : since_hs + 1;
            if (video.de && !prev_de) begin
                check_count("hs to de rise", since_hs, H_BPORCH - `PG_HS_OFFSET);
                line_de = 0;
            end
            if (video.de) begin
                line_de++;
            end
            if (!video.de && prev_de) begin
                check_count("de cycles per line", line_de, H_ACTIVE);
                lines++;
            end
            prev_de = video.de;
        end
        check_count("de lines per frame", lines, V_ACTIVE);
    endtask

    task automatic test_pixel_colors();
        wait_vs();
        for (int n = 0; n < FRAME; n++) begin
            check_video(video, expect_pixel(n), "pixel");
            next_cycle();
        end
    endtask

    // 40 frames from reset reach all four edges
    task automatic test_bouncing();
        apply_reset();
        wait_vs();
        track_frames(40);
    endtask

    task automatic test_reset_mid_run();
        pattern_gen_pkg::square_pos_t got;
        pattern_gen_pkg::square_pos_t exp;
        int offset;
        repeat (2) begin
            rng    = xorshift32(rng);
            offset = int'(rng % FRAME);
            repeat (offset) begin
                next_cycle();
            end
            apply_reset();
            wait_vs();
            // one step from the start corner
            exp.x = W'(X0 - 1);
            exp.y = W'(Y0 + 1);
            measure_square(got);
            check_square(got, exp);
            track_frames(3);
        end
    endtask

    initial begin
        audgen_mclk = 1'b0;
        reset_n     = 1'b0;
        cyc         = 0;
        checks      = 0;
        errors      = 0;
        rng         = 32'd26460;
        mx          = X0;
        my          = Y0;
        mdx         = pattern_gen_pkg::DIR_DEC;
        mdy         = pattern_gen_pkg::DIR_INC;

        test_reset_state();
        test_sync_timing();
        test_active_window();
        test_pixel_colors();
        test_bouncing();
        test_reset_mid_run();

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: pattern_gen_top.sv
/*
 * top level of the test-pattern core
 * raster timing and square motion feeding the pixel stage
 */

`timescale 1ns/1ps
`default_nettype none

`include "pattern_gen_cfg.svh"

module pattern_gen_top #(
    parameter int H_BPORCH    = `PG_H_BPORCH,
    parameter int H_ACTIVE    = `PG_H_ACTIVE,
    parameter int H_TOTAL     = `PG_H_TOTAL,
    parameter int V_BPORCH    = `PG_V_BPORCH,
    parameter int V_ACTIVE    = `PG_V_ACTIVE,
    parameter int V_TOTAL     = `PG_V_TOTAL,
    parameter int HS_OFFSET   = `PG_HS_OFFSET,
    parameter int SQUARE_SIZE = `PG_SQUARE_SIZE,
    parameter int SQUARE_X0   = `PG_SQUARE_X0,
    parameter int SQUARE_Y0   = `PG_SQUARE_Y0
) (
    input  logic                        audgen_mclk,
    input  logic                        reset_n,
    output pattern_gen_pkg::video_out_t video
);

    pattern_gen_pkg::raster_pos_t raster;
    pattern_gen_pkg::square_pos_t square;

    // raster position, every clock
    raster_timing #(
        .H_BPORCH  (H_BPORCH),
        .H_ACTIVE  (H_ACTIVE),
        .H_TOTAL   (H_TOTAL),
        .V_BPORCH  (V_BPORCH),
        .V_ACTIVE  (V_ACTIVE),
        .V_TOTAL   (V_TOTAL),
        .HS_OFFSET (HS_OFFSET)
    ) u_raster (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .raster      (raster)
    );

    // square corner, stepped on frame_tick
    square_motion #(
        .H_ACTIVE    (H_ACTIVE),
        .V_ACTIVE    (V_ACTIVE),
        .SQUARE_SIZE (SQUARE_SIZE),
        .SQUARE_X0   (SQUARE_X0),
        .SQUARE_Y0   (SQUARE_Y0)
    ) u_motion (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .raster      (raster),
        .square      (square)
    );

    // registered pixel stream
    pixel_compose #(
        .SQUARE_SIZE (SQUARE_SIZE),
        .BG_LEVEL    (`PG_BG_LEVEL)
    ) u_compose (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .raster      (raster),
        .square      (square),
        .video       (video)
    );

endmodule

`default_nettype wire

// File: pixel_compose.sv
/*
 * output stage of the test-pattern core
 * registered sync, data enable and pixel color
 */

`timescale 1ns/1ps
`default_nettype none

`include "pattern_gen_cfg.svh"

module pixel_compose #(
    parameter int SQUARE_SIZE = `PG_SQUARE_SIZE,
    parameter int BG_LEVEL    = `PG_BG_LEVEL
) (
    input  logic                         audgen_mclk,
    input  logic                         reset_n,
    input  pattern_gen_pkg::raster_pos_t raster,
    input  pattern_gen_pkg::square_pos_t square,
    output pattern_gen_pkg::video_out_t  video
);

    localparam int W = `PG_COORD_W;

    localparam logic [W-1:0] SIZE = W'(SQUARE_SIZE);
    localparam logic [7:0]   GRAY = 8'(BG_LEVEL);

    logic                  in_square;
    pattern_gen_pkg::rgb_t rgb_nxt;

    ////////////////////
    // color select
    ////////////////////

    always_comb begin
        // window test as offset from the corner, no overflow at the right edge
        in_square = (raster.vis_x >= square.x)
                 && ((raster.vis_x - square.x) < SIZE)
                 && (raster.vis_y >= square.y)
                 && ((raster.vis_y - square.y) < SIZE);

        // blanking is black
        rgb_nxt = '0;
        if (raster.active && !in_square) begin
            rgb_nxt.r = GRAY;
            rgb_nxt.g = GRAY;
            rgb_nxt.b = GRAY;
        end
    end

    ////////////////////
    // output register
    ////////////////////

    // one clock behind the raster position
    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            video <= '0;
        end else begin
            video.vs  <= raster.frame_tick;
            video.hs  <= raster.line_tick;
            video.de  <= raster.active;
            video.rgb <= rgb_nxt;
        end
    end

    // nothing but black outside the data-enable window
    a_blank_black: assert property (
        @(posedge audgen_mclk) disable iff (!reset_n)
        !video.de |-> (video.rgb == '0)
    );

endmodule

`default_nettype wire

// File: square_motion.sv
/*
 * bouncing square position for the test-pattern core
 * one step per frame on each axis, reversing at the active edges
 */

`timescale 1ns/1ps
`default_nettype none

`include "pattern_gen_cfg.svh"

module square_motion #(
    parameter int H_ACTIVE    = `PG_H_ACTIVE,
    parameter int V_ACTIVE    = `PG_V_ACTIVE,
    parameter int SQUARE_SIZE = `PG_SQUARE_SIZE,
    parameter int SQUARE_X0   = `PG_SQUARE_X0,
    parameter int SQUARE_Y0   = `PG_SQUARE_Y0
) (
    input  logic                         audgen_mclk,
    input  logic                         reset_n,
    input  pattern_gen_pkg::raster_pos_t raster,
    output pattern_gen_pkg::square_pos_t square
);

    localparam int W = `PG_COORD_W;

    // highest corner position that keeps the square inside
    localparam logic [W-1:0] X_MAX  = W'(H_ACTIVE - SQUARE_SIZE);
    localparam logic [W-1:0] Y_MAX  = W'(V_ACTIVE - SQUARE_SIZE);
    localparam logic [W-1:0] X_INIT = W'(SQUARE_X0);
    localparam logic [W-1:0] Y_INIT = W'(SQUARE_Y0);

    pattern_gen_pkg::dir_t dir_x;
    pattern_gen_pkg::dir_t dir_y;
    pattern_gen_pkg::dir_t dir_x_nxt;
    pattern_gen_pkg::dir_t dir_y_nxt;

    ////////////////////
    // step rule
    ////////////////////

    // reverse first when already sitting on the limit ahead
    function automatic pattern_gen_pkg::dir_t turn(
        input pattern_gen_pkg::dir_t dir,
        input logic [W-1:0]          pos,
        input logic [W-1:0]          limit
    );
        if (dir == pattern_gen_pkg::DIR_DEC && pos == '0) begin
            return pattern_gen_pkg::DIR_INC;
        end
        if (dir == pattern_gen_pkg::DIR_INC && pos == limit) begin
            return pattern_gen_pkg::DIR_DEC;
        end
        return dir;
    endfunction

    // one pixel along the direction in force
    function automatic logic [W-1:0] step(
        input pattern_gen_pkg::dir_t dir,
        input logic [W-1:0]          pos
    );
        if (dir == pattern_gen_pkg::DIR_INC) begin
            return pos + 1'b1;
        end
        return pos - 1'b1;
    endfunction

    always_comb begin
        dir_x_nxt = turn(dir_x, square.x, X_MAX);
        dir_y_nxt = turn(dir_y, square.y, Y_MAX);
    end

    ////////////////////
    // position state
    ////////////////////

    // update at the end of the frame_tick cycle, which lies well ahead
    // of the first active line
    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            square.x <= X_INIT;
            square.y <= Y_INIT;
            // start moving left and down
            dir_x    <= pattern_gen_pkg::DIR_DEC;
            dir_y    <= pattern_gen_pkg::DIR_INC;
        end else if (raster.frame_tick) begin
            dir_x    <= dir_x_nxt;
            dir_y    <= dir_y_nxt;
            square.x <= step(dir_x_nxt, square.x);
            square.y <= step(dir_y_nxt, square.y);
        end
    end

    // bounce keeps the whole square on screen
    a_in_bounds: assert property (
        @(posedge audgen_mclk) disable iff (!reset_n)
        (square.x <= X_MAX) && (square.y <= Y_MAX)
    );

endmodule

`default_nettype wire

// File: raster_timing.sv
/*
 * raster counters for the test-pattern core
 * wrapping x/y counts, active window, visible coordinates,
 * frame and line ticks
 */

`timescale 1ns/1ps
`default_nettype none

`include "pattern_gen_cfg.svh"

module raster_timing #(
    parameter int H_BPORCH  = `PG_H_BPORCH,
    parameter int H_ACTIVE  = `PG_H_ACTIVE,
    parameter int H_TOTAL   = `PG_H_TOTAL,
    parameter int V_BPORCH  = `PG_V_BPORCH,
    parameter int V_ACTIVE  = `PG_V_ACTIVE,
    parameter int V_TOTAL   = `PG_V_TOTAL,
    parameter int HS_OFFSET = `PG_HS_OFFSET
) (
    input  logic                         audgen_mclk,
    input  logic                         reset_n,
    output pattern_gen_pkg::raster_pos_t raster
);

    localparam int W = `PG_COORD_W;

    // compare points, sized to the counters
    localparam logic [W-1:0] H_LAST  = W'(H_TOTAL - 1);
    localparam logic [W-1:0] V_LAST  = W'(V_TOTAL - 1);
    localparam logic [W-1:0] H_START = W'(H_BPORCH);
    localparam logic [W-1:0] H_STOP  = W'(H_BPORCH + H_ACTIVE);
    localparam logic [W-1:0] V_START = W'(V_BPORCH);
    localparam logic [W-1:0] V_STOP  = W'(V_BPORCH + V_ACTIVE);
    localparam logic [W-1:0] HS_X    = W'(HS_OFFSET);

    logic [W-1:0] x_count;
    logic [W-1:0] y_count;
    logic         h_active;
    logic         v_active;

    ////////////////////
    // counters
    ////////////////////

    // x every clock, y on the x wrap
    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            x_count <= '0;
            y_count <= '0;
        end else if (x_count == H_LAST) begin
            x_count <= '0;
            if (y_count == V_LAST) begin
                y_count <= '0;
            end else begin
                y_count <= y_count + 1'b1;
            end
        end else begin
            x_count <= x_count + 1'b1;
        end
    end

    ////////////////////
    // decode
    ////////////////////

    always_comb begin
        // inside the window on each axis
        h_active = (x_count >= H_START) && (x_count < H_STOP);
        v_active = (y_count >= V_START) && (y_count < V_STOP);

        raster.x_count    = x_count;
        raster.y_count    = y_count;
        raster.vis_x      = x_count - H_START;
        raster.vis_y      = y_count - V_START;
        raster.active     = h_active && v_active;
        // top-left corner of the raster starts a frame
        raster.frame_tick = (x_count == '0) && (y_count == '0);
        raster.line_tick  = (x_count == HS_X);
    end

    // counters never leave the raster
    a_count_range: assert property (
        @(posedge audgen_mclk) disable iff (!reset_n)
        (x_count <= H_LAST) && (y_count <= V_LAST)
    );

    // vs and hs must stay apart on the output
    a_tick_apart: assert property (
        @(posedge audgen_mclk) disable iff (!reset_n)
        !(raster.frame_tick && raster.line_tick)
    );

endmodule

`default_nettype wire

// File: pattern_gen_pkg.sv
/*
 * shared types for the test-pattern core
 * raster position, square position, color, video output, motion direction
 */

`default_nettype none

`include "pattern_gen_cfg.svh"

package pattern_gen_pkg;

    // per-axis motion of the square
    typedef enum logic {
        DIR_DEC = 1'b0,
        DIR_INC = 1'b1
    } dir_t;

    ////////////////////
    // raster timing out
    ////////////////////
    typedef struct packed {
        logic [`PG_COORD_W-1:0] x_count;
        logic [`PG_COORD_W-1:0] y_count;
        // counts minus back porch, only meaningful when active
        logic [`PG_COORD_W-1:0] vis_x;
        logic [`PG_COORD_W-1:0] vis_y;
        logic                   active;
        logic                   frame_tick;
        logic                   line_tick;
    } raster_pos_t;

    // top-left corner of the square
    typedef struct packed {
        logic [`PG_COORD_W-1:0] x;
        logic [`PG_COORD_W-1:0] y;
    } square_pos_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

    // pixel stream to the scaler, one pixel per clock
    typedef struct packed {
        rgb_t rgb;
        logic de;
        logic vs;
        logic hs;
    } video_out_t;

endpackage

`default_nettype wire

// File: pattern_gen_cfg.svh
/*
 * raster, square and color defaults for the test-pattern core
 * 640x480 visible area inside an 800x500 raster
 */

`ifndef PATTERN_GEN_CFG_SVH
`define PATTERN_GEN_CFG_SVH

// width of every counter and coordinate
`define PG_COORD_W      10

////////////////////
// horizontal raster
////////////////////
`define PG_H_BPORCH     160
`define PG_H_ACTIVE     640
`define PG_H_TOTAL      800

////////////////////
// vertical raster
////////////////////
`define PG_V_BPORCH     20
`define PG_V_ACTIVE     480
`define PG_V_TOTAL      500

// hs lands a few clocks after vs, never on the same cycle
`define PG_HS_OFFSET    3

// square edge and start corner, visible coordinates
`define PG_SQUARE_SIZE  15
`define PG_SQUARE_X0    135
`define PG_SQUARE_Y0    95

// background gray, same level on r, g and b
`define PG_BG_LEVEL     60

`endif
